/* mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Datapath word, also the byte address width
`define DATA_W 32

// Destination register index
`define REG_ADDR_W 5

// Word address bits of the data RAM, 1024 words
`define DMEM_AW 10

// Byte lanes per data word
`define BE_W (`DATA_W / 8)

// Programmable RAM wait states, 0 to 7
`define WAIT_W 3

// APB byte address width
`define APB_AW 8

`endif

/* pipe_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package pipe_pkg;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic                   mem_read;     // Load
        logic                   mem_write;    // Store
        mem_size_e              size;         // Access width
        logic                   is_unsigned;  // Zero extend on load
        logic [`DATA_W-1:0]     alu_result;   // Byte address or plain result
        logic [`DATA_W-1:0]     store_data;   // Unshifted store operand
        logic                   reg_write;
        logic                   mem_to_reg;
        logic                   reg_data_src;
        logic                   pc_src;
        logic [`REG_ADDR_W-1:0] rd;
    } ex_mem_t;

    typedef struct packed {
        logic                   reg_write;
        logic                   mem_to_reg;
        logic                   reg_data_src;
        logic                   pc_src;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`DATA_W-1:0]     alu_result;
        logic [`DATA_W-1:0]     load_data;    // Already extended
    } mem_wb_t;

    typedef struct packed {
        logic                   req;          // Held until ack
        logic                   we;
        logic [`DMEM_AW-1:0]    addr;         // Word address
        logic [`BE_W-1:0]       be;
        logic [`DATA_W-1:0]     wdata;        // Lane aligned
    } ram_req_t;

    // One cycle pulses to the register block
    typedef struct packed {
        logic                   load_done;
        logic                   store_done;
        logic                   misalign;
        logic [`DATA_W-1:0]     fault_addr;
    } mem_event_t;

endpackage

`default_nettype wire

/* apb_pkg.sv */
`default_nettype none

`include "mem_params.svh"

package apb_pkg;

    typedef struct packed {
        logic                psel;
        logic                penable;     // Access phase
        logic                pwrite;
        logic [`APB_AW-1:0]  paddr;
        logic [`DATA_W-1:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`DATA_W-1:0]  prdata;
        logic                pready;      // Tied high
        logic                pslverr;
    } apb_rsp_t;

    // Register map
    localparam logic [`APB_AW-1:0] REG_WAIT       = 'h00;  // RW wait states
    localparam logic [`APB_AW-1:0] REG_STATUS     = 'h04;  // W1C misalign flag
    localparam logic [`APB_AW-1:0] REG_FAULT_ADDR = 'h08;  // RO
    localparam logic [`APB_AW-1:0] REG_LOAD_CNT   = 'h0C;  // RO
    localparam logic [`APB_AW-1:0] REG_STORE_CNT  = 'h10;  // RO

endpackage

`default_nettype wire

/* mem_stage.sv */
`default_nettype none

`include "mem_params.svh"

module mem_stage
    import pipe_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         in_valid,
    input  wire ex_mem_t      ex_mem,
    output logic              in_ready,
    output logic              out_valid,
    output mem_wb_t           mem_wb,
    output ram_req_t          ram_req,
    input  wire logic [`DATA_W-1:0] ram_rdata,
    input  wire logic         ram_ack,
    output mem_event_t        mem_event
);

    logic                 busy;        // Memory access in flight
    logic                 accept;
    logic                 is_mem;
    logic                 misaligned;
    ex_mem_t              pend;        // Record of the pending access
    logic                 req_q;
    logic                 req_we;
    logic [`DMEM_AW-1:0]  req_addr;
    logic [`BE_W-1:0]     req_be;
    logic [`DATA_W-1:0]   req_wdata;
    logic [`BE_W-1:0]     be_next;
    logic [`DATA_W-1:0]   lane;
    logic [`DATA_W-1:0]   load_ext;

    assign in_ready = !busy;                       // One access at a time
    assign accept   = in_valid && in_ready;
    assign is_mem   = ex_mem.mem_read || ex_mem.mem_write;

    // Alignment against access width
    always_comb
    begin
        case (ex_mem.size)
            SZ_HALF: misaligned = ex_mem.alu_result[0];
            SZ_WORD: misaligned = |ex_mem.alu_result[1:0];
            default: misaligned = 1'b0;            // Bytes always fit
        endcase
    end

    // Byte enables from width and low address bits
    always_comb
    begin
        case (ex_mem.size)
            SZ_BYTE: be_next = `BE_W'(4'b0001) << ex_mem.alu_result[1:0];
            SZ_HALF: be_next = `BE_W'(4'b0011) << {ex_mem.alu_result[1], 1'b0};
            default: be_next = '1;
        endcase
    end

    // Pick the addressed lane and extend it
    assign lane = ram_rdata >> {pend.alu_result[1:0], 3'b000};

    always_comb
    begin
        case (pend.size)
            SZ_BYTE: load_ext = pend.is_unsigned ? {{(`DATA_W-8){1'b0}}, lane[7:0]}
                                                 : {{(`DATA_W-8){lane[7]}}, lane[7:0]};
            SZ_HALF: load_ext = pend.is_unsigned ? {{(`DATA_W-16){1'b0}}, lane[15:0]}
                                                 : {{(`DATA_W-16){lane[15]}}, lane[15:0]};
            default: load_ext = ram_rdata;
        endcase
    end

    assign ram_req = '{req: req_q, we: req_we, addr: req_addr, be: req_be, wdata: req_wdata};

    // Handshake control and event pulses
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy      <= 1'b0;
            req_q     <= 1'b0;
            out_valid <= 1'b0;
            mem_event <= '0;
        end
        else
        begin
            out_valid <= 1'b0;
            mem_event <= '0;                       // Pulses last one cycle
            if (accept)
            begin
                if (is_mem && !misaligned)
                begin
                    busy  <= 1'b1;
                    req_q <= 1'b1;                 // Request in next cycle
                end
                else
                begin
                    out_valid            <= 1'b1;
                    mem_event.misalign   <= is_mem;
                    mem_event.fault_addr <= ex_mem.alu_result;
                end
            end
            else if (busy && ram_ack)
            begin
                busy                 <= 1'b0;
                req_q                <= 1'b0;
                out_valid            <= 1'b1;
                mem_event.load_done  <= pend.mem_read;
                mem_event.store_done <= pend.mem_write;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pend      <= ex_mem;
            req_we    <= ex_mem.mem_write;
            req_addr  <= ex_mem.alu_result[`DMEM_AW+1:2];
            req_be    <= be_next;
            req_wdata <= ex_mem.store_data << {ex_mem.alu_result[1:0], 3'b000};
            if (!is_mem || misaligned)
            begin
                mem_wb.reg_write    <= ex_mem.reg_write && !(is_mem && misaligned);
                mem_wb.mem_to_reg   <= ex_mem.mem_to_reg;
                mem_wb.reg_data_src <= ex_mem.reg_data_src;
                mem_wb.pc_src       <= ex_mem.pc_src;
                mem_wb.rd           <= ex_mem.rd;
                mem_wb.alu_result   <= ex_mem.alu_result;
                mem_wb.load_data    <= '0;
            end
        end
        else if (busy && ram_ack)
        begin
            mem_wb.reg_write    <= pend.reg_write;
            mem_wb.mem_to_reg   <= pend.mem_to_reg;
            mem_wb.reg_data_src <= pend.reg_data_src;
            mem_wb.pc_src       <= pend.pc_src;
            mem_wb.rd           <= pend.rd;
            mem_wb.alu_result   <= pend.alu_result;
            mem_wb.load_data    <= pend.mem_read ? load_ext : '0;
        end
    end

    // RAM sees a frozen request until it answers
    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        ram_req.req && !ram_ack |=> ram_req.req && $stable(ram_req));

    // A misaligned record never writes back or completes in the RAM
    a_misalign_no_wb: assert property (@(posedge clk) disable iff (rst)
        out_valid && (pend.mem_read || pend.mem_write)
            && ((pend.size == SZ_HALF && pend.alu_result[0])
                || (pend.size == SZ_WORD && pend.alu_result[1:0] != 2'b00))
        |-> !mem_wb.reg_write && !mem_event.load_done && !mem_event.store_done);

    a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
        accept |-> !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

/* data_ram.sv */
`default_nettype none

`include "mem_params.svh"

module data_ram
    import pipe_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire ram_req_t           ram_req,
    input  wire logic [`WAIT_W-1:0] wait_states,
    output logic [`DATA_W-1:0]      ram_rdata,
    output logic                    ram_ack
);

    logic [`DATA_W-1:0] mem [2**`DMEM_AW];   // No reset on storage
    logic               busy;                 // Counting wait states
    logic [`WAIT_W-1:0] cnt;
    logic               start;
    logic               fire;                 // Access happens this edge

    // New request only once the previous ack is gone
    assign start = ram_req.req && !busy && !ram_ack;
    assign fire  = (start && wait_states == '0) || (busy && cnt == `WAIT_W'(1));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            cnt     <= '0;
            ram_ack <= 1'b0;
        end
        else
        begin
            ram_ack <= fire;                  // Single cycle ack
            if (start && wait_states != '0)
            begin
                busy <= 1'b1;
                cnt  <= wait_states;          // Setting sampled here only
            end
            else if (busy)
            begin
                cnt <= cnt - 1'b1;
                if (cnt == `WAIT_W'(1))
                begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // Array access, byte lanes on write
    always_ff @(posedge clk)
    begin
        if (fire)
        begin
            ram_rdata <= mem[ram_req.addr];   // Whole word back
            if (ram_req.we)
            begin
                for (int i = 0; i < `BE_W; i++)
                begin
                    if (ram_req.be[i])
                    begin
                        mem[ram_req.addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    a_ack_has_req: assert property (@(posedge clk) disable iff (rst)
        ram_ack |-> ram_req.req);

endmodule

`default_nettype wire

/* mem_csr.sv */
`default_nettype none

`include "mem_params.svh"

module mem_csr
    import pipe_pkg::*, apb_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire apb_req_t           apb_req,
    input  wire mem_event_t         mem_event,
    output apb_rsp_t                apb_rsp,
    output logic [`WAIT_W-1:0]      wait_states
);

    logic               access;        // APB access phase
    logic               unmapped;
    logic               read_only;
    logic               wr_en;
    logic [`DATA_W-1:0] rdata;
    logic               fault_flag;    // Sticky
    logic [`DATA_W-1:0] fault_addr;
    logic [`DATA_W-1:0] load_cnt;
    logic [`DATA_W-1:0] store_cnt;

    assign access = apb_req.psel && apb_req.penable;

    // Offset decode and read mux
    always_comb
    begin
        unmapped  = 1'b0;
        read_only = 1'b0;
        rdata     = '0;
        case (apb_req.paddr)
            REG_WAIT:       rdata = {{(`DATA_W-`WAIT_W){1'b0}}, wait_states};
            REG_STATUS:     rdata = {{(`DATA_W-1){1'b0}}, fault_flag};
            REG_FAULT_ADDR:
            begin
                rdata     = fault_addr;
                read_only = 1'b1;
            end
            REG_LOAD_CNT:
            begin
                rdata     = load_cnt;
                read_only = 1'b1;
            end
            REG_STORE_CNT:
            begin
                rdata     = store_cnt;
                read_only = 1'b1;
            end
            default:        unmapped = 1'b1;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;        // No wait states on APB
    assign apb_rsp.pslverr = access && (unmapped || (apb_req.pwrite && read_only));
    assign wr_en           = access && apb_req.pwrite && !apb_rsp.pslverr;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wait_states <= '0;
            fault_flag  <= 1'b0;
            fault_addr  <= '0;
            load_cnt    <= '0;
            store_cnt   <= '0;
        end
        else
        begin
            if (wr_en && apb_req.paddr == REG_WAIT)
            begin
                wait_states <= apb_req.pwdata[`WAIT_W-1:0];
            end
            if (mem_event.misalign)
            begin
                fault_flag <= 1'b1;           // Set beats clear
            end
            else if (wr_en && apb_req.paddr == REG_STATUS && apb_req.pwdata[0])
            begin
                fault_flag <= 1'b0;
            end
            if (mem_event.misalign && !fault_flag)
            begin
                fault_addr <= mem_event.fault_addr;  // First fault only
            end
            if (mem_event.load_done)
            begin
                load_cnt <= load_cnt + 1'b1;  // Wraps
            end
            if (mem_event.store_done)
            begin
                store_cnt <= store_cnt + 1'b1;
            end
        end
    end

    a_penable_psel: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

/* mem_subsys.sv */
`default_nettype none

`include "mem_params.svh"

module mem_subsys
    import pipe_pkg::*, apb_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire ex_mem_t  ex_mem,
    output logic          in_ready,
    output logic          out_valid,
    output mem_wb_t       mem_wb,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp
);

    ram_req_t           ram_req;      // Stage to RAM
    logic [`DATA_W-1:0] ram_rdata;
    logic               ram_ack;
    logic [`WAIT_W-1:0] wait_states;  // CSR to RAM
    mem_event_t         mem_event;    // Stage to CSR

    mem_stage u_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .ex_mem    (ex_mem),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .mem_wb    (mem_wb),
        .ram_req   (ram_req),
        .ram_rdata (ram_rdata),
        .ram_ack   (ram_ack),
        .mem_event (mem_event)
    );

    data_ram u_ram (
        .clk         (clk),
        .rst         (rst),
        .ram_req     (ram_req),
        .wait_states (wait_states),
        .ram_rdata   (ram_rdata),
        .ram_ack     (ram_ack)
    );

    mem_csr u_csr (
        .clk         (clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .mem_event   (mem_event),
        .apb_rsp     (apb_rsp),
        .wait_states (wait_states)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;           // 100 ns period
    end

    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);         // Held for 3 cycles
        #10 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsys
    import pipe_pkg::*, apb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_LAT   = (1 << `WAIT_W) - 1 + 3;   // Slowest load or store
    localparam int BURST_LEN = 4;

    typedef enum logic [1:0] {OP_APB_WR, OP_APB_RD, OP_REC, OP_BURST} op_e;

    typedef struct packed {
        op_e                op;
        logic               ld;
        logic               st;
        mem_size_e          size;
        logic               uns;
        logic               err;          // Expected pslverr
        logic [`DATA_W-1:0] addr;         // APB offset or byte address
        logic [`DATA_W-1:0] data;         // pwdata or store data
        logic [`DATA_W-1:0] exp;          // Expected prdata
    } row_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    ex_mem_t            ex_mem;
    logic               in_ready;
    logic               out_valid;
    mem_wb_t            mem_wb;
    apb_req_t           apb_req;
    apb_rsp_t           apb_rsp;

    row_t               rows[$];
    string              names[$];
    logic               rows_ready;
    logic [`DATA_W-1:0] ref_mem [2**`DMEM_AW];   // Expected RAM contents
    logic [`WAIT_W-1:0] wait_cfg = '0;           // Wait setting as last written
    int                 n_loads = 0;
    int                 n_stores = 0;

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    mem_subsys uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .ex_mem    (ex_mem),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .mem_wb    (mem_wb),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    task automatic stop_with_failure(string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        assert (exp === act)
        else
        begin
            stop_with_failure($sformatf("ERR %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    function automatic logic is_misaligned(mem_size_e sz, logic [`DATA_W-1:0] a);
        return (sz == SZ_HALF && a[0]) || (sz == SZ_WORD && a[1:0] != 2'b00);
    endfunction

    // Byte lane rule for an aligned store
    function automatic void model_store(mem_size_e sz, logic [`DATA_W-1:0] a,
                                        logic [`DATA_W-1:0] d);
        case (sz)
            SZ_BYTE: ref_mem[a[`DMEM_AW+1:2]][8*a[1:0] +: 8] = d[7:0];
            SZ_HALF: ref_mem[a[`DMEM_AW+1:2]][16*a[1] +: 16] = d[15:0];
            default: ref_mem[a[`DMEM_AW+1:2]] = d;
        endcase
    endfunction

    function automatic logic [`DATA_W-1:0] predict_load(mem_size_e sz, logic uns,
                                                         logic [`DATA_W-1:0] a);
        logic [`DATA_W-1:0] w;
        logic [7:0]         b;
        logic [15:0]        h;
        w = ref_mem[a[`DMEM_AW+1:2]];
        b = w[8*a[1:0] +: 8];               // Lane from low address bits
        h = w[16*a[1] +: 16];
        case (sz)
            SZ_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            SZ_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default: return w;
        endcase
    endfunction

    function automatic ex_mem_t pass_record(logic [`DATA_W-1:0] a, int tag);
        ex_mem_t r;
        r = '0;
        r.alu_result   = a;
        r.size         = SZ_WORD;
        r.reg_write    = 1'b1;
        r.mem_to_reg   = tag[2];
        r.reg_data_src = tag[0];
        r.pc_src       = tag[1];
        r.rd           = 5'(tag + 1);
        return r;
    endfunction

    task automatic apb_row(string name, op_e op, logic [`APB_AW-1:0] off,
                           logic [`DATA_W-1:0] val, logic err);
        row_t r;
        r = '0;
        r.op   = op;
        r.addr = `DATA_W'(off);
        r.err  = err;
        r.data = val;                       // Write data
        r.exp  = val;                       // Read expectation
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic record_row(string name, logic ld, logic st, mem_size_e sz, logic uns,
                              logic [`DATA_W-1:0] a, logic [`DATA_W-1:0] d);
        row_t r;
        r = '0;
        r.op   = OP_REC;
        r.ld   = ld;
        r.st   = st;
        r.size = sz;
        r.uns  = uns;
        r.addr = a;
        r.data = d;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic burst_row(string name, logic [`DATA_W-1:0] a);
        row_t r;
        r = '0;
        r.op   = OP_BURST;
        r.addr = a;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_wb(string name, ex_mem_t r, logic rw);
        check_value({name, " out_valid"}, 1, out_valid);
        check_value({name, " wb fields"},
                    {rw, r.mem_to_reg, r.reg_data_src, r.pc_src, r.rd, r.alu_result},
                    {mem_wb.reg_write, mem_wb.mem_to_reg, mem_wb.reg_data_src,
                     mem_wb.pc_src, mem_wb.rd, mem_wb.alu_result});
    endtask

    // Setup then access, pready expected high
    task automatic apb_transfer(string name, row_t r);
        logic [`DATA_W-1:0] exp;
        logic [`DATA_W-1:0] rdata;
        logic               err;
        @(posedge clk);
        #10;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: r.op == OP_APB_WR,
                    paddr: r.addr[`APB_AW-1:0], pwdata: r.data};
        @(posedge clk);
        #10;
        apb_req.penable = 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value({name, " pready"}, 1, apb_rsp.pready);
        @(posedge clk);
        #10;
        apb_req = '0;
        check_value({name, " pslverr"}, r.err, err);
        if (r.op == OP_APB_RD && !r.err)
        begin
            exp = r.exp;
            if (r.addr == `DATA_W'(REG_LOAD_CNT))
                exp = n_loads;              // Counts from the table itself
            else if (r.addr == `DATA_W'(REG_STORE_CNT))
                exp = n_stores;
            check_value({name, " prdata"}, exp, rdata);
        end
        if (r.op == OP_APB_WR && !r.err && r.addr == `DATA_W'(REG_WAIT))
            wait_cfg = r.data[`WAIT_W-1:0];
    endtask

    task automatic drive_record(string name, row_t r, int idx);
        ex_mem_t rec;
        logic    mis;
        logic    aligned;
        int      exp_lat;
        int      lat;
        int      polls;
        rec             = pass_record(r.addr, idx);
        rec.mem_read    = r.ld;
        rec.mem_write   = r.st;
        rec.size        = r.size;
        rec.is_unsigned = r.uns;
        rec.store_data  = r.data;
        if (r.ld)
            rec.mem_to_reg = 1'b1;
        mis     = (r.ld || r.st) && is_misaligned(r.size, r.addr);
        aligned = (r.ld || r.st) && !mis;
        exp_lat = aligned ? int'(wait_cfg) + 3 : 1;
        @(posedge clk);
        #10;
        in_valid = 1'b1;
        ex_mem   = rec;
        polls    = 0;
        @(negedge clk);
        while (!in_ready)
        begin
            polls++;
            if (polls > MAX_LAT)
                stop_with_failure({name, ": the stage never raised in_ready"});
            @(negedge clk);
        end
        @(posedge clk);                     // Acceptance edge
        #10;
        in_valid = 1'b0;
        ex_mem   = '0;
        lat      = 0;
        do
        begin
            @(negedge clk);
            lat++;
            if (lat > MAX_LAT)
                stop_with_failure({name, ": out_valid never came after acceptance"});
            if (!out_valid)
                check_value({name, " in_ready"}, 0, in_ready);   // Stalled upstream
        end
        while (!out_valid);
        check_value({name, " latency"}, exp_lat, lat);
        check_wb(name, rec, !mis);
        if (aligned && r.ld)
        begin
            check_value({name, " load_data"}, predict_load(r.size, r.uns, r.addr),
                        mem_wb.load_data);
            n_loads++;
        end
        if (aligned && r.st)
        begin
            model_store(r.size, r.addr, r.data);
            n_stores++;
        end
    endtask

    // Pass-through records on consecutive cycles
    task automatic burst_records(string name, row_t r, int idx);
        @(posedge clk);
        #10;
        for (int i = 0; i < BURST_LEN; i++)
        begin
            in_valid = 1'b1;
            ex_mem   = pass_record(r.addr + i, idx + i);
            @(negedge clk);
            check_value({name, " in_ready"}, 1, in_ready);
            if (i > 0)
                check_wb(name, pass_record(r.addr + i - 1, idx + i - 1), 1'b1);
            @(posedge clk);
            #10;
        end
        in_valid = 1'b0;
        ex_mem   = '0;
        @(negedge clk);
        check_wb(name, pass_record(r.addr + BURST_LEN - 1, idx + BURST_LEN - 1), 1'b1);
    endtask

    task automatic build_table();
        logic [`DATA_W-1:0] a0;
        logic [`DATA_W-1:0] a1;
        a0 = ($urandom % 512) << 2;         // Lower half of the RAM
        a1 = 32'h800 + (($urandom % 256) << 2);
        apb_row("wait reset", OP_APB_RD, REG_WAIT, 0, 1'b0);
        apb_row("status reset", OP_APB_RD, REG_STATUS, 0, 1'b0);
        record_row("pass alu", 1'b0, 1'b0, SZ_WORD, 1'b0, 32'h1234_5678, 0);
        burst_row("pass burst", 32'hcafe_0000);
        record_row("sw rand", 1'b0, 1'b1, SZ_WORD, 1'b0, a0, $urandom);
        record_row("lw rand", 1'b1, 1'b0, SZ_WORD, 1'b0, a0, 0);
        record_row("sw pattern", 1'b0, 1'b1, SZ_WORD, 1'b0, a1, 32'h80ff_7f01);
        for (int k = 0; k < 4; k++)
        begin
            record_row($sformatf("lb %0d", k), 1'b1, 1'b0, SZ_BYTE, 1'b0, a1 + k, 0);
            record_row($sformatf("lbu %0d", k), 1'b1, 1'b0, SZ_BYTE, 1'b1, a1 + k, 0);
        end
        for (int k = 0; k < 4; k += 2)
        begin
            record_row($sformatf("lh %0d", k), 1'b1, 1'b0, SZ_HALF, 1'b0, a1 + k, 0);
            record_row($sformatf("lhu %0d", k), 1'b1, 1'b0, SZ_HALF, 1'b1, a1 + k, 0);
        end
        record_row("sb lane1", 1'b0, 1'b1, SZ_BYTE, 1'b0, a1 + 1, $urandom);
        record_row("sh upper", 1'b0, 1'b1, SZ_HALF, 1'b0, a1 + 2, $urandom);
        record_row("lw merged", 1'b1, 1'b0, SZ_WORD, 1'b0, a1, 0);
        record_row("sb lane3", 1'b0, 1'b1, SZ_BYTE, 1'b0, a0 + 3, $urandom);
        record_row("lw lane3", 1'b1, 1'b0, SZ_WORD, 1'b0, a0, 0);
        for (int w = 0; w < 8; w++)
        begin
            apb_row($sformatf("wait set %0d", w), OP_APB_WR, REG_WAIT, w, 1'b0);
            record_row($sformatf("lw wait %0d", w), 1'b1, 1'b0, SZ_WORD, 1'b0, a0, 0);
        end
        record_row("sh wait 7", 1'b0, 1'b1, SZ_HALF, 1'b0, a0, $urandom);
        apb_row("wait high bits", OP_APB_WR, REG_WAIT, 32'h9, 1'b0);   // Only bit 0 kept
        apb_row("wait readback", OP_APB_RD, REG_WAIT, 1, 1'b0);
        record_row("lw wait 1", 1'b1, 1'b0, SZ_WORD, 1'b0, a0, 0);
        record_row("sw misaligned", 1'b0, 1'b1, SZ_WORD, 1'b0, a0 + 1, $urandom);
        apb_row("status set", OP_APB_RD, REG_STATUS, 1, 1'b0);
        apb_row("fault addr", OP_APB_RD, REG_FAULT_ADDR, a0 + 1, 1'b0);
        record_row("lh misaligned", 1'b1, 1'b0, SZ_HALF, 1'b0, a1 + 3, 0);
        apb_row("fault addr kept", OP_APB_RD, REG_FAULT_ADDR, a0 + 1, 1'b0);
        record_row("lw after bad sw", 1'b1, 1'b0, SZ_WORD, 1'b0, a0, 0);
        apb_row("status clear", OP_APB_WR, REG_STATUS, 1, 1'b0);
        apb_row("status cleared", OP_APB_RD, REG_STATUS, 0, 1'b0);
        record_row("sh misaligned", 1'b0, 1'b1, SZ_HALF, 1'b0, a1 + 1, $urandom);
        apb_row("fault addr new", OP_APB_RD, REG_FAULT_ADDR, a1 + 1, 1'b0);
        apb_row("load count", OP_APB_RD, REG_LOAD_CNT, 0, 1'b0);
        apb_row("store count", OP_APB_RD, REG_STORE_CNT, 0, 1'b0);
        apb_row("unmapped read", OP_APB_RD, 8'h14, 0, 1'b1);
        apb_row("ro write", OP_APB_WR, REG_LOAD_CNT, 32'h55, 1'b1);
        apb_row("load count kept", OP_APB_RD, REG_LOAD_CNT, 0, 1'b0);
    endtask

    // Watchdog sized from the table length
    initial
    begin
        wait (rows_ready === 1'b1);
        repeat (3 + rows.size() * (MAX_LAT + 4)) @(posedge clk);
        stop_with_failure("Watchdog expired before the table was done");
    end

    initial
    begin
        in_valid   = 1'b0;
        ex_mem     = '0;
        apb_req    = '0;
        rows_ready = 1'b0;
        void'($urandom(32'ha29));           // Single seed for the run
        build_table();
        rows_ready = 1'b1;
        wait (rst === 1'b0);
        for (int i = 0; i < rows.size(); i++)
        begin
            case (rows[i].op)
                OP_APB_WR, OP_APB_RD: apb_transfer(names[i], rows[i]);
                OP_REC:               drive_record(names[i], rows[i], i);
                default:              burst_records(names[i], rows[i], i);
            endcase
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
pipe_pkg.sv
apb_pkg.sv
mem_stage.sv
data_ram.sv
mem_csr.sv
mem_subsys.sv
tb_clk_gen.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_mem_subsys -f filelist.f -o sim_mem_subsys || exit 1
out=$(./obj_dir/sim_mem_subsys)
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
